// ==== hw/sink_defs.svh ====
// Widths shared by the sink design. The bank word must be wider than a stream word plus 3 bytes.
`ifndef SINK_DEFS_SVH
`define SINK_DEFS_SVH

// Width of one bank word in bits.
`define SINK_MEM_DW 64

// Width of one stream word in bits.
`define SINK_STRM_DW 32

// Width of a byte address.
`define SINK_AW 12

// Width of the job word count.
`define SINK_CNT_W 8

`endif

// ==== hw/sink_pkg.sv ====
// Types of the sink design. The job count must be at least one.
`default_nettype none

`include "sink_defs.svh"

package sink_pkg;

  // Streamer FSM states.
  typedef enum logic [1:0] {
    IDLE,
    WORKING,
    DRAIN
  } streamer_state_e;

  // Job description as the top level assembles it.
  typedef struct packed {
    logic [`SINK_AW-1:0]    base_addr;  // Byte address of the first word.
    logic [7:0]             stride;     // Distance between words, in bank words.
    logic [`SINK_CNT_W-1:0] tot_len;    // Number of stream words in the job.
  } sink_ctrl_t;

  // Status of the address generator.
  typedef struct packed {
    logic done;  // High once the last address has been queued.
  } addrgen_flags_t;

endpackage

`default_nettype wire

// ==== hw/tcdm_if.sv ====
// Write-only memory request bus. A write takes place on an edge where req and gnt are both high.
`default_nettype none

`include "sink_defs.svh"

interface tcdm_if;

  logic                       req;
  logic                       gnt;
  logic [`SINK_AW-1:0]        add;   // Byte address, word aligned.
  logic [`SINK_MEM_DW/8-1:0]  be;    // One enable per byte lane.
  logic [`SINK_MEM_DW-1:0]    data;

  // The requester side.
  modport master (
    output req, add, be, data,
    input  gnt
  );

  // The memory side, which grants.
  modport slave (
    input  req, add, be, data,
    output gnt
  );

endinterface

`default_nettype wire

// ==== hw/sink_addressgen.sv ====
// Address generator with a two-entry queue. The job fields must stay stable while it is enabled.
`default_nettype none

`include "sink_defs.svh"

module sink_addressgen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     enable_i,
  input  sink_pkg::sink_ctrl_t     ctrl_i,
  output logic [`SINK_AW-1:0]      addr_o,
  output logic                     addr_valid_o,
  input  logic                     addr_ready_i,
  output sink_pkg::addrgen_flags_t flags_o
);

  logic [`SINK_CNT_W-1:0] cnt_q;
  logic [`SINK_AW-1:0]    offs_q;
  logic                   done_q;
  logic                   push;
  logic                   pop;
  logic                   full;
  logic [`SINK_AW-1:0]    queue_q [2];
  logic                   wr_ptr_q;
  logic                   rd_ptr_q;
  logic [1:0]             fill_q;

  assign full = (fill_q == 2'd2);
  assign push = enable_i & ~done_q & ~full;  // The counter stalls on a full queue.
  assign pop  = addr_valid_o & addr_ready_i;

  // Counts the queued addresses and walks the offset in whole bank words.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      offs_q <= '0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q  <= '0;
      offs_q <= '0;
      done_q <= 1'b0;
    end else if (push) begin
      cnt_q  <= cnt_q + 1'b1;
      offs_q <= offs_q + `SINK_AW'({ctrl_i.stride, 3'b000});
      done_q <= (cnt_q + 1'b1 == ctrl_i.tot_len);
    end
  end

  // Queue pointers and fill level.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      fill_q   <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      fill_q   <= '0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      fill_q <= fill_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) queue_q[wr_ptr_q] <= ctrl_i.base_addr + offs_q;
  end

  assign addr_o        = queue_q[rd_ptr_q];
  assign addr_valid_o  = (fill_q != 2'd0);
  assign flags_o.done  = done_q;

endmodule

`default_nettype wire

// ==== hw/sink_core.sv ====
// Streamer control and byte alignment. Address bit 2 is ignored, so each word lands in bank bytes 0 to 6.
`default_nettype none

`include "sink_defs.svh"

module sink_core (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       start_i,
  input  sink_pkg::sink_ctrl_t       ctrl_i,
  input  logic [`SINK_STRM_DW-1:0]   strm_data_i,
  input  logic [`SINK_STRM_DW/8-1:0] strm_strb_i,
  input  logic                       strm_valid_i,
  output logic                       strm_ready_o,
  input  logic [`SINK_AW-1:0]        addr_i,
  input  logic                       addr_valid_i,
  output logic                       addr_ready_o,
  input  sink_pkg::addrgen_flags_t   agen_flags_i,
  output logic                       agen_en_o,
  output logic                       agen_clr_o,
  tcdm_if.master                     tcdm,
  output logic                       ready_start_o,
  output logic                       done_o
);

  sink_pkg::streamer_state_e cs, ns;

  logic                      active;
  logic                      accept;
  logic                      last_accept;
  logic                      done_d;
  logic [`SINK_CNT_W-1:0]    cnt_q;
  logic [`SINK_CNT_W-1:0]    cnt_d;
  logic [1:0]                boffs;
  logic [`SINK_MEM_DW-1:0]   data_ext;
  logic [`SINK_MEM_DW-1:0]   data_aligned;
  logic [`SINK_MEM_DW/8-1:0] strb_ext;
  logic [`SINK_MEM_DW/8-1:0] strb_aligned;

  assign active = (cs != sink_pkg::IDLE);
  assign boffs  = addr_i[1:0];  // Byte offset inherited from the base address.

  // The stream word sits in the low lanes and moves up by the byte offset.
  assign data_ext     = {{(`SINK_MEM_DW - `SINK_STRM_DW){1'b0}}, strm_data_i};
  assign strb_ext     = {{((`SINK_MEM_DW - `SINK_STRM_DW) / 8){1'b0}}, strm_strb_i};
  assign data_aligned = data_ext << {boffs, 3'b000};
  assign strb_aligned = strb_ext << boffs;

  // A request needs both a word and an address, so it never waits on gnt.
  assign tcdm.req  = active & strm_valid_i & addr_valid_i;
  assign tcdm.add  = {addr_i[`SINK_AW-1:2], 2'b00};
  assign tcdm.be   = active ? strb_aligned : '0;
  assign tcdm.data = active ? data_aligned : '0;

  // Word, address and write retire in the same cycle.
  assign accept       = tcdm.req & tcdm.gnt;
  assign strm_ready_o = active & addr_valid_i & tcdm.gnt;
  assign addr_ready_o = accept;

  assign cnt_d       = cnt_q + 1'b1;
  assign last_accept = accept & agen_flags_i.done & (cnt_d == ctrl_i.tot_len);

  always_comb begin
    ns         = cs;
    done_d     = 1'b0;
    agen_en_o  = 1'b0;
    agen_clr_o = 1'b0;
    unique case (cs)
      sink_pkg::IDLE: begin
        if (start_i) begin
          ns        = sink_pkg::WORKING;
          agen_en_o = 1'b1;  // The first address is queued during the start cycle.
        end
      end
      sink_pkg::WORKING: begin
        agen_en_o = 1'b1;
        if (agen_flags_i.done) ns = sink_pkg::DRAIN;
      end
      sink_pkg::DRAIN: begin
        agen_en_o = 1'b1;
      end
      default: ns = sink_pkg::IDLE;
    endcase
    // The last word ends the job straight away, from either busy state.
    if (last_accept) begin
      ns         = sink_pkg::IDLE;
      done_d     = 1'b1;
      agen_en_o  = 1'b0;
      agen_clr_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs     <= sink_pkg::IDLE;
      done_o <= 1'b0;
    end else begin
      cs     <= ns;
      done_o <= done_d;  // High for one cycle, together with the return to IDLE.
    end
  end

  // Accepted-word counter.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (last_accept) begin
      cnt_q <= '0;
    end else if (accept) begin
      cnt_q <= cnt_d;
    end
  end

  assign ready_start_o = ~active;

endmodule

`default_nettype wire

// ==== hw/tcdm_bank.sv ====
// Single 64-word bank; a read wins over a write in the same cycle and the contents are not reset.
`default_nettype none

`include "sink_defs.svh"

module tcdm_bank (
  input  logic                    clk_i,
  tcdm_if.slave                   tcdm,
  input  logic                    rd_req_i,
  input  logic [`SINK_AW-1:0]     rd_addr_i,
  output logic [`SINK_MEM_DW-1:0] rd_data_o
);

  localparam int unsigned bank_depth = 64;
  localparam int unsigned idx_w      = $clog2(bank_depth);

  logic [`SINK_MEM_DW-1:0] mem_q [bank_depth];
  logic [idx_w-1:0]        wr_idx;
  logic [idx_w-1:0]        rd_idx;

  // Bits 2:0 select a byte inside a bank word.
  assign wr_idx = tcdm.add[idx_w+2:3];
  assign rd_idx = rd_addr_i[idx_w+2:3];

  assign tcdm.gnt = ~rd_req_i;  // The read port has priority.

  always_ff @(posedge clk_i) begin
    if (tcdm.req && tcdm.gnt) begin
      for (int b = 0; b < `SINK_MEM_DW / 8; b++) begin
        if (tcdm.be[b]) begin
          mem_q[wr_idx][8*b +: 8] <= tcdm.data[8*b +: 8];
        end
      end
    end
    if (rd_req_i) begin
      rd_data_o <= mem_q[rd_idx];  // Valid one cycle after the request.
    end
  end

endmodule

`default_nettype wire

// ==== hw/sink_top.sv ====
// Sink top level. Base, stride and count must be held stable from start until done.
`default_nettype none

`include "sink_defs.svh"

module sink_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       start_i,
  input  logic [`SINK_AW-1:0]        base_addr_i,
  input  logic [7:0]                 stride_i,
  input  logic [`SINK_CNT_W-1:0]     tot_len_i,
  input  logic [`SINK_STRM_DW-1:0]   strm_data_i,
  input  logic [`SINK_STRM_DW/8-1:0] strm_strb_i,
  input  logic                       strm_valid_i,
  output logic                       strm_ready_o,
  input  logic                       rd_req_i,
  input  logic [`SINK_AW-1:0]        rd_addr_i,
  output logic [`SINK_MEM_DW-1:0]    rd_data_o,
  output logic                       ready_start_o,
  output logic                       done_o
);

  sink_pkg::sink_ctrl_t     ctrl;
  sink_pkg::addrgen_flags_t agen_flags;
  logic [`SINK_AW-1:0]      addr;
  logic                     addr_valid;
  logic                     addr_ready;
  logic                     agen_en;
  logic                     agen_clr;

  tcdm_if tcdm ();

  assign ctrl = '{base_addr: base_addr_i, stride: stride_i, tot_len: tot_len_i};

  sink_addressgen i_addressgen (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( agen_clr   ),
    .enable_i     ( agen_en    ),
    .ctrl_i       ( ctrl       ),
    .addr_o       ( addr       ),
    .addr_valid_o ( addr_valid ),
    .addr_ready_i ( addr_ready ),
    .flags_o      ( agen_flags )
  );

  sink_core i_core (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .start_i       ( start_i       ),
    .ctrl_i        ( ctrl          ),
    .strm_data_i   ( strm_data_i   ),
    .strm_strb_i   ( strm_strb_i   ),
    .strm_valid_i  ( strm_valid_i  ),
    .strm_ready_o  ( strm_ready_o  ),
    .addr_i        ( addr          ),
    .addr_valid_i  ( addr_valid    ),
    .addr_ready_o  ( addr_ready    ),
    .agen_flags_i  ( agen_flags    ),
    .agen_en_o     ( agen_en       ),
    .agen_clr_o    ( agen_clr      ),
    .tcdm          ( tcdm.master   ),
    .ready_start_o ( ready_start_o ),
    .done_o        ( done_o        )
  );

  tcdm_bank i_bank (
    .clk_i     ( clk_i      ),
    .tcdm      ( tcdm.slave ),
    .rd_req_i  ( rd_req_i   ),
    .rd_addr_i ( rd_addr_i  ),
    .rd_data_o ( rd_data_o  )
  );

endmodule

`default_nettype wire

// ==== sim/sink_checker.sv ====
// Bound into sink_core; the checks are inactive while rst_ni is low.
`default_nettype none

module sink_checker (
  input logic       clk_i,
  input logic       rst_ni,
  input logic [1:0] state_i,
  input logic       req_i,
  input logic       done_i,
  input logic       addr_valid_i,
  input logic       addr_ready_i,
  input logic       ready_start_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic idle;

  assign idle = (state_i == sink_pkg::IDLE);

  // The done pulse lasts one cycle.
  done_pulse_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i
  ) else $error("done_o stayed high for more than one cycle");

  // An idle streamer has an empty address queue and raises no request.
  no_req_in_idle_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) idle |-> !req_i && !addr_valid_i
  ) else $error("memory request or address pending while the streamer is idle");

  // An offered address is held until it is taken.
  addr_hold_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (addr_valid_i && !addr_ready_i) |=> addr_valid_i
  ) else $error("address valid dropped before the address was accepted");

  // Ready comes back in the cycle of the done pulse and at no other time.
  ready_start_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(ready_start_i) == done_i
  ) else $error("ready_start_o rose out of step with done_o");

endmodule

bind sink_core sink_checker checker_inst (
  .clk_i         ( clk_i         ),
  .rst_ni        ( rst_ni        ),
  .state_i       ( cs            ),
  .req_i         ( tcdm.req      ),
  .done_i        ( done_o        ),
  .addr_valid_i  ( addr_valid_i  ),
  .addr_ready_i  ( addr_ready_o  ),
  .ready_start_i ( ready_start_o )
);

`default_nettype wire

// ==== sim/sink_tb.sv ====
// Testbench for sink_top; runs from the project root and reads sim/sink_tests.txt.
`default_nettype none

`include "sink_defs.svh"

module sink_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       start_i;
  logic [`SINK_AW-1:0]        base_addr_i;
  logic [7:0]                 stride_i;
  logic [`SINK_CNT_W-1:0]     tot_len_i;
  logic [`SINK_STRM_DW-1:0]   strm_data_i;
  logic [`SINK_STRM_DW/8-1:0] strm_strb_i;
  logic                       strm_valid_i;
  logic                       strm_ready_o;
  logic                       rd_req_i;
  logic [`SINK_AW-1:0]        rd_addr_i;
  logic [`SINK_MEM_DW-1:0]    rd_data_o;
  logic                       ready_start_o;
  logic                       done_o;

  logic [31:0] tv [0:255];     // Raw tokens of the job file.
  logic [7:0]  model [64][8];  // Expected bank bytes.
  logic        known [64][8];  // Bytes written at least once.
  int          seed;
  int          data_errors;
  int          proto_errors;
  int          done_count;

  sink_top sink_top_inst (.*);

  always #2 clk_i = ~clk_i;

  // Counts done pulses where the flop output is stable.
  always @(negedge clk_i) begin
    if (rst_ni && done_o) done_count++;
  end

  task automatic abort_run(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("** FAIL **");
    $finish;
  endtask

  // Updates the byte model for word k of a job.
  task automatic model_write(input int base, input int stride, input int k,
                             input logic [31:0] data, input logic [3:0] strb);
    int addr;
    int idx;
    int off;
    addr = (base + k * stride * 8) & 32'hfff;
    idx  = (addr >> 3) & 63;
    off  = base & 3;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model[idx][off+b] = data[8*b +: 8];
        known[idx][off+b] = 1'b1;
      end
    end
  endtask

  task automatic run_job(input int p);
    int n;
    int idx;
    int cyc;
    int t;
    bit took;
    bit seen;
    n = tv[p+2];
    for (t = 0; t < 100 && !ready_start_o; t++) @(negedge clk_i);
    if (!ready_start_o) abort_run("ready_start_o never rose");
    @(posedge clk_i);
    start_i     <= 1'b1;
    base_addr_i <= tv[p][`SINK_AW-1:0];
    stride_i    <= tv[p+1][7:0];
    tot_len_i   <= tv[p+2][`SINK_CNT_W-1:0];
    for (int k = 0; k < n; k++) begin
      model_write(tv[p], tv[p+1], k, tv[p+3+2*k], tv[p+4+2*k][3:0]);
    end
    idx  = 0;
    cyc  = 0;
    took = 1'b0;
    while (1) begin
      @(posedge clk_i);
      if (took) idx++;
      if (idx == n) begin
        strm_valid_i <= 1'b0;
        rd_req_i     <= 1'b0;
        start_i      <= 1'b0;
        break;
      end
      start_i <= (cyc == 3);  // A stray start in mid job must be ignored.
      if (!strm_valid_i || took) strm_valid_i <= (($random(seed) & 3) != 0);
      strm_data_i <= tv[p+3+2*idx];
      strm_strb_i <= tv[p+4+2*idx][3:0];
      rd_req_i    <= (($random(seed) & 3) == 0);
      rd_addr_i   <= `SINK_AW'($random(seed));
      @(negedge clk_i);
      if (cyc > 0 && ready_start_o) begin
        $display("CHECK FAILED at %0t ns: ready_start_o high during a job", $time);
        proto_errors++;
      end
      took = strm_valid_i && strm_ready_o;
      cyc++;
      if (cyc > 2000) abort_run("stream words were not accepted");
    end
    seen = 1'b0;
    for (t = 0; t < 50 && !seen; t++) begin
      @(negedge clk_i);
      seen = done_o;
      // Done follows the last accepted word at once, with the engine idle again.
      if (seen && (t != 0 || !ready_start_o)) begin
        $display("CHECK FAILED at %0t ns: done_o late or engine still busy", $time);
        proto_errors++;
      end
    end
    if (!seen) abort_run("done_o never pulsed");
  endtask

  // Reads every bank word and compares the bytes that the model knows.
  task automatic check_bank();
    for (int w = 0; w < 64; w++) begin
      @(posedge clk_i);
      rd_req_i  <= 1'b1;
      rd_addr_i <= `SINK_AW'(w << 3);
      @(posedge clk_i);
      rd_req_i <= 1'b0;
      @(negedge clk_i);
      for (int b = 0; b < 8; b++) begin
        if (known[w][b] && rd_data_o[8*b +: 8] !== model[w][b]) begin
          $display("CHECK FAILED at %0t ns: word %0d byte %0d is %h, expected %h",
                   $time, w, b, rd_data_o[8*b +: 8], model[w][b]);
          data_errors++;
        end
      end
    end
  endtask

  initial begin
    int p;
    int jobs;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    start_i      = 1'b0;
    base_addr_i  = '0;
    stride_i     = '0;
    tot_len_i    = '0;
    strm_data_i  = '0;
    strm_strb_i  = '0;
    strm_valid_i = 1'b0;
    rd_req_i     = 1'b0;
    rd_addr_i    = '0;
    seed         = 32'h6d07;
    data_errors  = 0;
    proto_errors = 0;
    done_count   = 0;
    for (int w = 0; w < 64; w++) begin
      for (int b = 0; b < 8; b++) begin
        model[w][b] = 8'h00;
        known[w][b] = 1'b0;
      end
    end
    $readmemh("sim/sink_tests.txt", tv);
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (done_o || strm_ready_o || !ready_start_o) begin
      $display("CHECK FAILED at %0t ns: outputs wrong after reset", $time);
      proto_errors++;
    end
    p    = 0;
    jobs = 0;
    while (tv[p+2] != 0) begin
      run_job(p);
      jobs++;
      check_bank();
      if (done_count != jobs) begin
        $display("CHECK FAILED at %0t ns: %0d done pulses after %0d jobs",
                 $time, done_count, jobs);
        proto_errors++;
      end
      if (!ready_start_o) begin
        $display("CHECK FAILED at %0t ns: engine busy after done", $time);
        proto_errors++;
      end
      p = p + 3 + 2 * tv[p+2];
    end
    $display("Jobs %0d, data errors %0d, protocol errors %0d", jobs, data_errors, proto_errors);
    if (data_errors == 0 && proto_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/sink_tests.txt ====
// One job per line: base stride count, then count pairs of data and strobe (hex).
// A count of zero ends the list.
000 01 04 03020100 f 07060504 f 0b0a0908 f 0f0e0d0c f
040 03 04 11223344 f 55667788 f 99aabbcc f ddeeff00 f
0a1 01 05 deadbeef f cafef00d 5 12345678 a 9abcdef0 f 0badc0de 3
102 02 05 a5a5a5a5 f 5a5a5a5a 9 c3c3c3c3 f 3c3c3c3c 6 f00fba11 f
1f3 01 04 01234567 f 89abcdef e fedcba98 7 76543210 f
001 01 04 ffffffff 2 eeeeeeee 4 dddddddd 8 cccccccc 1
000 00 00

// ==== tb.f ====
+incdir+hw
hw/sink_pkg.sv
hw/tcdm_if.sv
hw/sink_addressgen.sv
hw/sink_core.sv
hw/tcdm_bank.sv
hw/sink_top.sv
sim/sink_checker.sv
sim/sink_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' tb.f) hw/sink_defs.svh

.PHONY: run clean

run: obj_dir/Vsink_tb
	./obj_dir/Vsink_tb | tee /dev/stderr | grep -qF '** PASS **'

obj_dir/Vsink_tb: tb.f $(SRCS) sim/sink_tests.txt
	verilator --binary --timing --assert --top-module sink_tb -f tb.f

clean:
	rm -rf obj_dir
